//--- hw/ecc_pkg.sv
package ecc_pkg;

    localparam int DATA_WIDTH   = 42;
    localparam int PARITY_WIDTH = 7;
    localparam int CODE_WIDTH   = DATA_WIDTH + PARITY_WIDTH;
    localparam int MEM_DEPTH    = 64;
    localparam int ADDR_WIDTH   = $clog2(MEM_DEPTH);
    localparam int CNT_WIDTH    = 16;

    typedef logic [DATA_WIDTH-1:0]   ecc_data_t;
    typedef logic [PARITY_WIDTH-1:0] ecc_parity_t;
    typedef logic [ADDR_WIDTH-1:0]   ecc_addr_t;

    // Stored word, data in the upper bits and check bits below
    typedef struct packed {
        ecc_data_t   data;
        ecc_parity_t parity;
    } ecc_code_t;

    // Column i is the syndrome seen when data bit i flips
    localparam ecc_parity_t ECC_H_COLUMNS [DATA_WIDTH] = '{
        7'b1000011, 7'b1000101, 7'b1000110, 7'b0000111, 7'b1001001, 7'b1001010, // 0 to 5
        7'b0001011, 7'b1001100, 7'b0001101, 7'b0001110, 7'b1001111, 7'b1010001, // 6 to 11
        7'b1010010, 7'b0010011, 7'b1010100, 7'b0010101, 7'b0010110, 7'b1010111, // 12 to 17
        7'b1011000, 7'b0011001, 7'b0011010, 7'b1011011, 7'b0011100, 7'b1011101, // 18 to 23
        7'b1011110, 7'b0011111, 7'b1100001, 7'b1100010, 7'b0100011, 7'b1100100, // 24 to 29
        7'b0100101, 7'b0100110, 7'b1100111, 7'b1101000, 7'b0101001, 7'b0101010, // 30 to 35
        7'b1101011, 7'b0101100, 7'b1101101, 7'b1101110, 7'b0101111, 7'b1110000  // 36 to 41
    };

    // Check bit j is the parity of every data bit whose column has bit j set
    function automatic ecc_parity_t ecc_check_bits(input ecc_data_t data);
        ecc_parity_t p;
        p = '0;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            p = p ^ (ECC_H_COLUMNS[i] & {PARITY_WIDTH{data[i]}});
        end
        return p;
    endfunction

endpackage

//--- hw/ecc_encode_inject.sv
`timescale 1ns/1ps

module ecc_encode_inject (
    input  ecc_pkg::ecc_data_t wr_data,
    input  ecc_pkg::ecc_code_t wr_flip,
    output ecc_pkg::ecc_code_t wr_code
);

    import ecc_pkg::*;

    ecc_code_t clean_code;

    always_comb begin
        clean_code.data   = wr_data;
        clean_code.parity = ecc_check_bits(wr_data);
    end

    // Flip mask may hit data or check bits, one set bit per planted error
    assign wr_code = ecc_code_t'(clean_code ^ wr_flip);

endmodule

//--- hw/ecc_mem_array.sv
`timescale 1ns/1ps

module ecc_mem_array (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               wr_en,
    input  ecc_pkg::ecc_addr_t wr_addr,
    input  ecc_pkg::ecc_code_t wr_code,
    input  logic               rd_en,
    input  ecc_pkg::ecc_addr_t rd_addr,
    output logic               rd_valid,
    output ecc_pkg::ecc_code_t rd_code,
    output ecc_pkg::ecc_addr_t rd_addr_q
);

    import ecc_pkg::*;

    ecc_code_t mem [MEM_DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_code;
        end
    end

    // Same-edge read of a written address sees the old word
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_code   <= mem[rd_addr];
            rd_addr_q <= rd_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en; // One cycle read latency
        end
    end

endmodule

//--- hw/ecc_secded_decoder.sv
`timescale 1ns/1ps

module ecc_secded_decoder (
    input  ecc_pkg::ecc_code_t   code_in,
    input  logic                 bypass,
    output ecc_pkg::ecc_data_t   data_out,
    output ecc_pkg::ecc_parity_t parity_out,
    output logic                 sbit_err,
    output logic                 dbit_err
);

    import ecc_pkg::*;

    ecc_parity_t syndrome;
    ecc_data_t   flip_mask;
    logic        data_hit;
    logic        check_hit;
    logic        syn_nonzero;

    assign parity_out = ecc_check_bits(code_in.data);
    assign syndrome   = parity_out ^ code_in.parity;

    // Find the data bit whose column equals the syndrome
    always_comb begin
        flip_mask = '0;
        data_hit  = 1'b0;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            if (syndrome == ECC_H_COLUMNS[i]) begin
                flip_mask[i] = 1'b1;
                data_hit     = 1'b1;
            end
        end
    end

    assign syn_nonzero = |syndrome;

    // A single set bit in the syndrome points at a flipped check bit
    assign check_hit = syn_nonzero && ((syndrome & (syndrome - ecc_parity_t'(1))) == '0);

    assign data_out = bypass ? code_in.data : code_in.data ^ flip_mask;
    assign sbit_err = !bypass && (data_hit || check_hit);
    assign dbit_err = !bypass && syn_nonzero && !data_hit && !check_hit; // Data left as stored

endmodule

//--- hw/ecc_err_log.sv
`timescale 1ns/1ps

module ecc_err_log (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         valid,
    input  logic                         sbit_err,
    input  logic                         dbit_err,
    input  ecc_pkg::ecc_addr_t           err_addr,
    output logic [ecc_pkg::CNT_WIDTH-1:0] sbit_count,
    output logic [ecc_pkg::CNT_WIDTH-1:0] dbit_count,
    output ecc_pkg::ecc_addr_t           last_err_addr
);

    logic sbit_hit;
    logic dbit_hit;

    assign sbit_hit = valid && sbit_err;
    assign dbit_hit = valid && dbit_err;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sbit_count <= '0;
        end else if (sbit_hit && !(&sbit_count)) begin
            sbit_count <= sbit_count + 1'b1; // Holds at all ones
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dbit_count <= '0;
        end else if (dbit_hit && !(&dbit_count)) begin
            dbit_count <= dbit_count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            last_err_addr <= '0;
        end else if (sbit_hit || dbit_hit) begin
            last_err_addr <= err_addr;
        end
    end

endmodule

//--- hw/ecc_mem_top.sv
`timescale 1ns/1ps

module ecc_mem_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          wr_en,
    input  ecc_pkg::ecc_addr_t            wr_addr,
    input  ecc_pkg::ecc_data_t            wr_data,
    input  ecc_pkg::ecc_code_t            wr_flip,
    input  logic                          rd_en,
    input  ecc_pkg::ecc_addr_t            rd_addr,
    input  logic                          bypass,
    output logic                          rd_valid,
    output ecc_pkg::ecc_data_t            rd_data,
    output ecc_pkg::ecc_parity_t          rd_parity,
    output logic                          sbit_err,
    output logic                          dbit_err,
    output logic [ecc_pkg::CNT_WIDTH-1:0] sbit_count,
    output logic [ecc_pkg::CNT_WIDTH-1:0] dbit_count,
    output ecc_pkg::ecc_addr_t            last_err_addr
);

    import ecc_pkg::*;

    ecc_code_t wr_code;
    ecc_code_t rd_code;
    ecc_addr_t rd_addr_q;

    ecc_encode_inject u_encode (
        .wr_data (wr_data),
        .wr_flip (wr_flip),
        .wr_code (wr_code)
    );

    ecc_mem_array u_array (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_code   (wr_code),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_valid  (rd_valid),
        .rd_code   (rd_code),
        .rd_addr_q (rd_addr_q)
    );

    ecc_secded_decoder u_decode (
        .code_in    (rd_code),
        .bypass     (bypass),
        .data_out   (rd_data),
        .parity_out (rd_parity),
        .sbit_err   (sbit_err),
        .dbit_err   (dbit_err)
    );

    // Logged at the edge that closes the rd_valid cycle
    ecc_err_log u_log (
        .clk           (clk),
        .rst_n         (rst_n),
        .valid         (rd_valid),
        .sbit_err      (sbit_err),
        .dbit_err      (dbit_err),
        .err_addr      (rd_addr_q),
        .sbit_count    (sbit_count),
        .dbit_count    (dbit_count),
        .last_err_addr (last_err_addr)
    );

endmodule

//--- dv/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk; // 10 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1; // Released with the same skew as the stimulus
    end

endmodule

//--- dv/tb_ecc_mem.sv
`timescale 1ns/1ps

module tb_ecc_mem;

    import ecc_pkg::*;

    typedef struct packed {
        ecc_data_t   data;
        ecc_parity_t parity;
        logic        sbit;
        logic        dbit;
        ecc_addr_t   addr;
    } exp_t;

    localparam int DOUBLE_RUNS   = 32;
    localparam int RANDOM_RUNS   = 64;
    localparam int BYPASS_RUNS   = 16;
    localparam int RDW_RUNS      = 4;
    localparam int NUM_OPS       = 2 * MEM_DEPTH + 2 * CODE_WIDTH + 2 * DOUBLE_RUNS
                                 + 2 * RANDOM_RUNS + 2 * BYPASS_RUNS + 3 * RDW_RUNS;
    localparam int MARGIN_CYCLES = 100;
    localparam ecc_code_t NO_FLIP = '0;

    logic                 clk;
    logic                 rst_n;
    logic                 wr_en;
    ecc_addr_t            wr_addr;
    ecc_data_t            wr_data;
    ecc_code_t            wr_flip;
    logic                 rd_en;
    ecc_addr_t            rd_addr;
    logic                 bypass;
    logic                 rd_valid;
    ecc_data_t            rd_data;
    ecc_parity_t          rd_parity;
    logic                 sbit_err;
    logic                 dbit_err;
    logic [CNT_WIDTH-1:0] sbit_count;
    logic [CNT_WIDTH-1:0] dbit_count;
    ecc_addr_t            last_err_addr;

    ecc_data_t   shadow_data [MEM_DEPTH];
    ecc_code_t   shadow_flip [MEM_DEPTH];
    exp_t        exp_q [$];
    logic        rd_issued = 1'b0;
    int          sbit_tally = 0;
    int          dbit_tally = 0;
    ecc_addr_t   last_addr_tally = '0;
    logic [31:0] rng_state = 32'd80;

    tb_clk_gen u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    ecc_mem_top i_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .wr_flip       (wr_flip),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .bypass        (bypass),
        .rd_valid      (rd_valid),
        .rd_data       (rd_data),
        .rd_parity     (rd_parity),
        .sbit_err      (sbit_err),
        .dbit_err      (dbit_err),
        .sbit_count    (sbit_count),
        .dbit_count    (dbit_count),
        .last_err_addr (last_err_addr)
    );

    function automatic logic [31:0] rand32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic ecc_data_t rand_data();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = rand32();
        lo = rand32();
        return {hi[DATA_WIDTH-33:0], lo};
    endfunction

    function automatic ecc_addr_t rand_addr();
        logic [31:0] r;
        r = rand32();
        return r[ADDR_WIDTH-1:0];
    endfunction

    function automatic ecc_code_t one_hot_flip(input logic [$clog2(CODE_WIDTH)-1:0] pos);
        ecc_code_t m;
        m = '0;
        m[pos] = 1'b1;
        return m;
    endfunction

    // Distinct positions anywhere in the codeword, data or check bits
    function automatic ecc_code_t rand_flip(input int nflips);
        ecc_code_t m;
        logic [31:0] r;
        m = '0;
        while ($countones(m) < nflips) begin
            r = rand32();
            m = m | one_hot_flip($clog2(CODE_WIDTH)'(r % CODE_WIDTH));
        end
        return m;
    endfunction

    // Check bit j is the parity of the data bits picked out by row j of the code matrix
    function automatic ecc_parity_t ref_check_bits(input ecc_data_t data);
        ecc_parity_t p;
        ecc_data_t   row;
        for (int j = 0; j < PARITY_WIDTH; j++) begin
            for (int i = 0; i < DATA_WIDTH; i++) begin
                row[i] = ECC_H_COLUMNS[i][j];
            end
            p[j] = ^(data & row);
        end
        return p;
    endfunction

    // Expected result from the flip count alone
    function automatic exp_t expected_read(input ecc_data_t data, input ecc_code_t flip,
                                           input logic byp, input ecc_addr_t addr);
        exp_t e;
        int   nflips;
        nflips = $countones(flip);
        e.addr = addr;
        e.sbit = 1'b0;
        e.dbit = 1'b0;
        e.parity = ref_check_bits(data ^ flip.data); // Taken over the stored data field
        if (byp) begin
            e.data = data ^ flip.data;
        end else if (nflips == 0) begin
            e.data = data;
        end else if (nflips == 1) begin
            e.data = data;
            e.sbit = 1'b1;
        end else begin
            e.data = data ^ flip.data; // Two flips are detected but left as stored
            e.dbit = 1'b1;
        end
        return e;
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("MISMATCH time=%0t signal=%s got=0x%0h expected=0x%0h",
                                    $time, name, got, exp));
        end
    endtask

    task automatic drive_cycle(input logic we, input ecc_addr_t wa, input ecc_data_t wd,
                               input ecc_code_t wf, input logic re, input ecc_addr_t ra);
        @(posedge clk);
        #1;
        wr_en   = we;
        wr_addr = wa;
        wr_data = wd;
        wr_flip = wf;
        rd_en   = re;
        rd_addr = ra;
        if (re) begin
            exp_q.push_back(expected_read(shadow_data[ra], shadow_flip[ra], bypass, ra));
        end
        if (we) begin
            shadow_data[wa] = wd; // After the read, so a same-edge read sees the old word
            shadow_flip[wa] = wf;
        end
    endtask

    task automatic write_word(input ecc_addr_t a, input ecc_data_t d, input ecc_code_t f);
        drive_cycle(1'b1, a, d, f, 1'b0, '0);
    endtask

    task automatic read_word(input ecc_addr_t a);
        drive_cycle(1'b0, '0, '0, NO_FLIP, 1'b1, a);
    endtask

    task automatic idle_cycle();
        drive_cycle(1'b0, '0, '0, NO_FLIP, 1'b0, '0);
    endtask

    // Bypass feeds the decoder directly, so it only moves with no read in flight
    task automatic set_bypass(input logic v);
        idle_cycle();
        idle_cycle();
        bypass = v;
    endtask

    task automatic write_then_read(input ecc_code_t f);
        ecc_addr_t a;
        a = rand_addr();
        write_word(a, rand_data(), f);
        read_word(a);
    endtask

    always @(posedge clk) begin
        rd_issued <= rd_en;
    end

    always @(negedge clk) begin : compare_read
        exp_t e;
        if (rst_n) begin
            check_value("sbit_count", 64'(sbit_count), 64'(sbit_tally));
            check_value("dbit_count", 64'(dbit_count), 64'(dbit_tally));
            check_value("last_err_addr", 64'(last_err_addr), 64'(last_addr_tally));
            if (rd_valid !== rd_issued) begin
                stop_on_error($sformatf("rd_valid is %b at %0t but a read was %s one cycle before",
                                        rd_valid, $time, rd_issued ? "issued" : "not issued"));
            end else if (rd_valid) begin
                if (exp_q.size() == 0) begin
                    stop_on_error("A read result arrived with no expected entry");
                end else begin
                    e = exp_q.pop_front();
                    check_value("rd_data", 64'(rd_data), 64'(e.data));
                    check_value("rd_parity", 64'(rd_parity), 64'(e.parity));
                    check_value("sbit_err", 64'(sbit_err), 64'(e.sbit));
                    check_value("dbit_err", 64'(dbit_err), 64'(e.dbit));
                    if (e.sbit) sbit_tally++;
                    if (e.dbit) dbit_tally++;
                    if (e.sbit || e.dbit) last_addr_tally = e.addr;
                end
            end
        end
    end

    initial begin : watchdog
        #((NUM_OPS + MARGIN_CYCLES) * 10);
        stop_on_error("The run timed out before all tests finished");
    end

    initial begin : stimulus
        ecc_addr_t a;
        ecc_data_t d_old;
        ecc_data_t d_new;
        wr_en   = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        wr_flip = '0;
        rd_en   = 1'b0;
        rd_addr = '0;
        bypass  = 1'b0;
        @(posedge rst_n);
        check_value("rd_valid", 64'(rd_valid), 64'(0));
        check_value("sbit_count", 64'(sbit_count), 64'(0));
        check_value("dbit_count", 64'(dbit_count), 64'(0));
        check_value("last_err_addr", 64'(last_err_addr), 64'(0));

        for (int i = 0; i < MEM_DEPTH; i++) begin
            write_word(ecc_addr_t'(i), rand_data(), NO_FLIP);
        end
        for (int i = 0; i < MEM_DEPTH; i++) begin
            read_word(ecc_addr_t'(i)); // One read per cycle
        end

        for (int b = 0; b < CODE_WIDTH; b++) begin
            write_then_read(one_hot_flip($clog2(CODE_WIDTH)'(b)));
        end
        for (int i = 0; i < DOUBLE_RUNS; i++) begin
            write_then_read(rand_flip(2));
        end
        for (int i = 0; i < RANDOM_RUNS; i++) begin
            write_then_read(rand_flip(int'(rand32() % 3)));
        end

        set_bypass(1'b1);
        for (int i = 0; i < BYPASS_RUNS; i++) begin
            write_then_read(rand_flip(1 + int'(rand32() % 2)));
        end
        set_bypass(1'b0);

        for (int i = 0; i < RDW_RUNS; i++) begin
            a     = rand_addr();
            d_old = rand_data();
            d_new = rand_data();
            write_word(a, d_old, NO_FLIP);
            drive_cycle(1'b1, a, d_new, NO_FLIP, 1'b1, a);
            read_word(a);
        end

        repeat (3) idle_cycle();
        if (exp_q.size() != 0) begin
            stop_on_error("Some reads never returned rd_valid before the end of the run");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

//--- tb.f
hw/ecc_pkg.sv
hw/ecc_encode_inject.sv
hw/ecc_mem_array.sv
hw/ecc_secded_decoder.sv
hw/ecc_err_log.sv
hw/ecc_mem_top.sv
dv/tb_clk_gen.sv
dv/tb_ecc_mem.sv

//--- Makefile
SIM := obj_dir/Vtb_ecc_mem

.PHONY: all run clean

all: $(SIM)

$(SIM): tb.f $(wildcard hw/*.sv dv/*.sv)
	verilator --binary --timing -j 0 --top-module tb_ecc_mem -f tb.f

run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir
